/* Bender.yml */
package:
  name: stc_mod

sources:
  - src/stcPkg.sv
  - src/stcIfs.sv
  - src/stcRegDecode.sv
  - src/pnGenerator.sv
  - src/stcFramer.sv
  - src/dacOutput.sv
  - src/stcModTop.sv
  - target: test
    files:
      - verif/stcMod_props.sv
      - verif/stcModTb.sv

/* project.f */
src/stcPkg.sv
src/stcIfs.sv
src/stcRegDecode.sv
src/pnGenerator.sv
src/stcFramer.sv
src/dacOutput.sv
src/stcModTop.sv
verif/stcMod_props.sv
verif/stcModTb.sv

/* src/dacOutput.sv */
// DAC output path: bit mapping, channel sum, source select and offset-binary format
`timescale 1ns/1ps
`default_nettype none

module dacOutput import stcPkg::*; (
    input  logic    clk,
    input  logic    reset,
    stcCfgIf.user   cfg,
    stcSymIf.sink   sym,
    output dacWordT dac0Data,
    output dacWordT dac1Data,
    output logic    dacValid,
    output logic    dacFrameStart
);

    localparam sampleT  BitLevel   = sampleT'(1) << (SampleW - 2);  // 18'h10000
    localparam sampleT  FrameLevel = sampleT'(1) << (SampleW - 1);  // 18'h20000
    localparam dacWordT DacMid     = dacWordT'(1) << (DacW - 1);

    sampleT gain0Ext;
    sampleT gain1Ext;
    sampleT ch0Sample;
    sampleT ch1Sample;
    sampleT txSample;
    sampleT dac0Sample;
    sampleT dac1Sample;
    logic   stage1Valid;
    logic   stage1Frame;

    function automatic sampleT selectSource(input dacSourceE src, input logic ownBit);
        sampleT result;
        case (src)
            SrcCh1:   result = ch1Sample;
            SrcTx:    result = txSample;
            SrcBits:  result = ownBit ? BitLevel : '0;
            SrcFrame: result = sym.frameStart ? FrameLevel : (sym.sym0 ? BitLevel : '0);
            default:  result = ch0Sample;  // SrcCh0 and unused codes
        endcase
        return result;
    endfunction

    // Top bits with the sign flipped
    function automatic dacWordT toOffsetBinary(input sampleT s);
        return {~s[SampleW-1], s[SampleW-2:SampleW-DacW]};
    endfunction

    //**************************************************************************
    // Stage 1, bit to amplitude and source select
    //**************************************************************************
    assign gain0Ext  = sampleT'(cfg.gain0);
    assign gain1Ext  = sampleT'(cfg.gain1);
    assign ch0Sample = sym.sym0 ? gain0Ext : -gain0Ext;
    assign ch1Sample = sym.sym1 ? gain1Ext : -gain1Ext;
    assign txSample  = ch0Sample + ch1Sample;  // Cannot overflow 18 bits

    always_ff @(posedge clk) begin
        if (sym.symValid) begin
            dac0Sample <= selectSource(cfg.dac0Source, sym.sym0);
            dac1Sample <= selectSource(cfg.dac1Source, sym.sym1);
        end
    end

    //**************************************************************************
    // Stage 2, DAC format
    //**************************************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            stage1Valid   <= 1'b0;
            stage1Frame   <= 1'b0;
            dacValid      <= 1'b0;
            dacFrameStart <= 1'b0;
            dac0Data      <= DacMid;
            dac1Data      <= DacMid;
        end else begin
            stage1Valid   <= sym.symValid;
            stage1Frame   <= sym.symValid && sym.frameStart;
            dacValid      <= stage1Valid;
            dacFrameStart <= stage1Frame;
            if (stage1Valid) begin
                dac0Data <= toOffsetBinary(dac0Sample);
                dac1Data <= toOffsetBinary(dac1Sample);
            end
        end
    end

endmodule

`default_nettype wire

/* src/pnGenerator.sv */
// Programmable-length Galois PN sequence generator
`timescale 1ns/1ps
`default_nettype none

module pnGenerator import stcPkg::*; (
    input  logic  clk,
    input  logic  reset,
    stcCfgIf.user cfg,
    input  logic  pnStep,
    input  logic  pnRestart,
    output logic  pnBit
);

    logic [5:0] activeLen;  // pnLength + 1, may exceed PnW
    pnTapsT     lenMask;
    pnTapsT     tapsMasked;
    pnTapsT     shifted;
    pnTapsT     pnState;

    assign activeLen  = cfg.pnLength + 6'd1;
    assign lenMask    = ~({PnW{1'b1}} << activeLen);
    assign tapsMasked = cfg.pnTaps & lenMask;

    // Shift right, fold taps back in when a one drops out
    assign shifted = {1'b0, pnState[PnW-1:1]} ^ (pnState[0] ? tapsMasked : '0);

    always_ff @(posedge clk) begin
        if (reset || pnRestart) begin
            pnState <= lenMask;  // All ones over the active length
        end else begin
            // Masking every cycle also trims the state after a length change
            pnState <= (pnStep ? shifted : pnState) & lenMask;
        end
    end

    assign pnBit = pnState[0];

endmodule

`default_nettype wire

/* src/stcFramer.sv */
// STC framer: symbol timing, sync word insertion and channel bit pairing
`timescale 1ns/1ps
`default_nettype none

module stcFramer import stcPkg::*; #(
    parameter int SymbolDiv = 4
) (
    input  logic    clk,
    input  logic    reset,
    stcCfgIf.user   cfg,
    input  logic    pnBit,
    output logic    pnStep,
    output logic    pnRestart,
    stcSymIf.framer sym
);

    localparam int DivW     = $clog2(SymbolDiv);
    localparam int IdxW     = $clog2(FrameLen);
    localparam int SyncIdxW = $clog2(SyncLen);

    logic [DivW-1:0]     divCount;
    logic [IdxW-1:0]     symIndex;   // Position within the frame
    logic                symStrobe;
    logic                inSync;
    logic [SyncIdxW-1:0] syncBit;
    logic                prevBit;    // Last payload sym0 of this frame

    assign symStrobe = cfg.txEnable && (divCount == DivW'(SymbolDiv - 1));
    assign inSync    = (symIndex < IdxW'(SyncLen));
    assign syncBit   = SyncIdxW'(SyncLen - 1) - symIndex[SyncIdxW-1:0];  // MSB first

    assign pnStep    = symStrobe && !inSync;
    assign pnRestart = !cfg.txEnable;  // Keeps PN at all ones while idle

    //**************************************************************************
    // Symbol and frame counters
    //**************************************************************************
    always_ff @(posedge clk) begin
        if (reset || !cfg.txEnable) begin
            divCount <= '0;
            symIndex <= '0;
        end else if (symStrobe) begin
            divCount <= '0;
            if (symIndex == IdxW'(FrameLen - 1)) begin
                symIndex <= '0;
            end else begin
                symIndex <= symIndex + 1'b1;
            end
        end else begin
            divCount <= divCount + 1'b1;
        end
    end

    // Strobes
    always_ff @(posedge clk) begin
        if (reset) begin
            sym.symValid   <= 1'b0;
            sym.frameStart <= 1'b0;
        end else begin
            sym.symValid   <= symStrobe;
            sym.frameStart <= symStrobe && (symIndex == '0);
        end
    end

    // Channel bits, held between symbols
    always_ff @(posedge clk) begin
        if (symStrobe) begin
            if (inSync) begin
                sym.sym0 <= SyncWord0[syncBit];
                sym.sym1 <= SyncWord1[syncBit];
            end else begin
                sym.sym0 <= pnBit;
                // Pair with the inverse of the previous payload bit
                sym.sym1 <= (symIndex == IdxW'(SyncLen)) ? 1'b1 : !prevBit;
                prevBit  <= pnBit;
            end
        end
    end

endmodule

`default_nettype wire

/* src/stcIfs.sv */
// Configuration and symbol interfaces between the STC modulator blocks
`timescale 1ns/1ps
`default_nettype none

// Register settings fanned out from the decoder
interface stcCfgIf import stcPkg::*; ();

    pnTapsT    pnTaps;
    pnLenT     pnLength;
    logic      txEnable;
    gainT      gain0;
    gainT      gain1;
    dacSourceE dac0Source;
    dacSourceE dac1Source;

    modport decoder (
        output pnTaps, pnLength, txEnable,
        output gain0, gain1,
        output dac0Source, dac1Source
    );

    modport user (
        input pnTaps, pnLength, txEnable,
        input gain0, gain1,
        input dac0Source, dac1Source
    );

endinterface

// Channel bit pair per symbol, no back-pressure
interface stcSymIf;

    logic sym0;
    logic sym1;
    logic symValid;    // One cycle per symbol
    logic frameStart;  // Symbol 0 of a frame

    modport framer (
        output sym0, sym1, symValid, frameStart
    );

    modport sink (
        input sym0, sym1, symValid, frameStart
    );

endinterface

`default_nettype wire

/* src/stcModTop.sv */
// Two-channel STC test modulator top level
`timescale 1ns/1ps
`default_nettype none

module stcModTop import stcPkg::*; #(
    parameter logic [15:0] VersionNumber = 16'd539,
    parameter int          SymbolDiv     = 4
) (
    input  logic    clk,
    input  logic    reset,

    // Register bus
    input  logic    busReq,
    input  logic    busWrite,
    input  busAddrT busAddr,
    input  busDataT busWrData,
    output logic    busAck,
    output busDataT busRdData,

    // DAC ports
    output dacWordT dac0Data,
    output dacWordT dac1Data,
    output logic    dacValid,
    output logic    dacFrameStart
);

    stcCfgIf cfgBus ();
    stcSymIf symBus ();

    logic pnStep;
    logic pnRestart;
    logic pnBit;

    //**************************************************************************
    // Decode
    //**************************************************************************
    stcRegDecode #(
        .VersionNumber(VersionNumber)
    ) regDecode (
        .clk       (clk),
        .reset     (reset),
        .busReq    (busReq),
        .busWrite  (busWrite),
        .busAddr   (busAddr),
        .busWrData (busWrData),
        .busAck    (busAck),
        .busRdData (busRdData),
        .cfg       (cfgBus)
    );

    //**************************************************************************
    // Execute, PN source and framer
    //**************************************************************************
    pnGenerator pnGen (
        .clk       (clk),
        .reset     (reset),
        .cfg       (cfgBus),
        .pnStep    (pnStep),
        .pnRestart (pnRestart),
        .pnBit     (pnBit)
    );

    stcFramer #(
        .SymbolDiv(SymbolDiv)
    ) framer (
        .clk       (clk),
        .reset     (reset),
        .cfg       (cfgBus),
        .pnBit     (pnBit),
        .pnStep    (pnStep),
        .pnRestart (pnRestart),
        .sym       (symBus)
    );

    // Result
    dacOutput dacOut (
        .clk           (clk),
        .reset         (reset),
        .cfg           (cfgBus),
        .sym           (symBus),
        .dac0Data      (dac0Data),
        .dac1Data      (dac1Data),
        .dacValid      (dacValid),
        .dacFrameStart (dacFrameStart)
    );

endmodule

`default_nettype wire

/* src/stcPkg.sv */
// STC modulator shared widths, types, register map and frame constants
`default_nettype none

package stcPkg;

    //**************************************************************************
    // Data widths and types
    //**************************************************************************
    localparam int SampleW = 18;
    localparam int DacW    = 14;
    localparam int GainW   = 16;
    localparam int PnW     = 24;  // Longest PN register

    typedef logic signed [SampleW-1:0] sampleT;
    typedef logic signed [GainW-1:0]   gainT;
    typedef logic [PnW-1:0]            pnTapsT;
    typedef logic [4:0]                pnLenT;
    typedef logic [DacW-1:0]           dacWordT;
    typedef logic [3:0]                busAddrT;
    typedef logic [31:0]               busDataT;

    //**************************************************************************
    // Register map
    //**************************************************************************
    typedef enum logic [3:0] {
        RegVersion  = 4'd0,  // Read only
        RegPnTaps   = 4'd1,
        RegPnLength = 4'd2,
        RegControl  = 4'd3,
        RegGain0    = 4'd4,
        RegGain1    = 4'd5
    } regAddrE;

    // RegControl fields
    localparam int CtlTxEnable = 0;
    localparam int CtlDac0Lsb  = 4;
    localparam int CtlDac1Lsb  = 8;

    localparam pnLenT PnLenReset = 5'd23;  // 24-bit sequence out of reset

    // DAC sources, unused codes fall back to channel 0
    typedef enum logic [3:0] {
        SrcCh0   = 4'd0,
        SrcCh1   = 4'd1,
        SrcTx    = 4'd2,
        SrcBits  = 4'd3,
        SrcFrame = 4'd4
    } dacSourceE;

    // Frame layout
    localparam int FrameLen = 32;
    localparam int SyncLen  = 8;
    localparam logic [SyncLen-1:0] SyncWord0 = 8'hB8;
    localparam logic [SyncLen-1:0] SyncWord1 = 8'h47;

endpackage

`default_nettype wire

/* src/stcRegDecode.sv */
// Register bus decoder with four-phase req/ack handshake and config register file
`timescale 1ns/1ps
`default_nettype none

module stcRegDecode import stcPkg::*; #(
    parameter logic [15:0] VersionNumber = 16'd539
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     busReq,
    input  logic     busWrite,
    input  busAddrT  busAddr,
    input  busDataT  busWrData,
    output logic     busAck,
    output busDataT  busRdData,
    stcCfgIf.decoder cfg
);

    typedef enum logic {
        HsIdle,
        HsAck
    } hsStateE;

    hsStateE   hsState;
    logic      access;   // One cycle per request
    regAddrE   regAddr;
    busDataT   readMux;

    pnTapsT    pnTaps;
    pnLenT     pnLength;
    logic      txEnable;
    gainT      gain0;
    gainT      gain1;
    dacSourceE dac0Source;
    dacSourceE dac1Source;

    assign regAddr = regAddrE'(busAddr);
    assign access  = (hsState == HsIdle) && busReq;
    assign busAck  = (hsState == HsAck);

    //**************************************************************************
    // Handshake FSM
    //**************************************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            hsState <= HsIdle;
        end else begin
            case (hsState)
                HsIdle:  hsState <= busReq ? HsAck : HsIdle;
                HsAck:   hsState <= busReq ? HsAck : HsIdle;  // Wait for req to drop
                default: hsState <= HsIdle;
            endcase
        end
    end

    // Register writes
    always_ff @(posedge clk) begin
        if (reset) begin
            pnTaps     <= '0;
            pnLength   <= PnLenReset;
            txEnable   <= 1'b0;
            gain0      <= '0;
            gain1      <= '0;
            dac0Source <= SrcCh0;
            dac1Source <= SrcCh0;
        end else if (access && busWrite) begin
            case (regAddr)
                RegPnTaps:   pnTaps <= busWrData[PnW-1:0];
                RegPnLength: pnLength <= busWrData[$bits(pnLenT)-1:0];
                RegControl: begin
                    txEnable   <= busWrData[CtlTxEnable];
                    dac0Source <= dacSourceE'(busWrData[CtlDac0Lsb +: 4]);
                    dac1Source <= dacSourceE'(busWrData[CtlDac1Lsb +: 4]);
                end
                RegGain0:    gain0 <= busWrData[GainW-1:0];
                RegGain1:    gain1 <= busWrData[GainW-1:0];
                default:     ;  // Version and unmapped ignored
            endcase
        end
    end

    // Read mux, unused bits stay zero
    always_comb begin
        readMux = '0;
        case (regAddr)
            RegVersion:  readMux[15:0] = VersionNumber;
            RegPnTaps:   readMux[PnW-1:0] = pnTaps;
            RegPnLength: readMux[$bits(pnLenT)-1:0] = pnLength;
            RegControl: begin
                readMux[CtlTxEnable]     = txEnable;
                readMux[CtlDac0Lsb +: 4] = dac0Source;
                readMux[CtlDac1Lsb +: 4] = dac1Source;
            end
            RegGain0:    readMux[GainW-1:0] = gain0;
            RegGain1:    readMux[GainW-1:0] = gain1;
            default:     readMux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (access) begin
            busRdData <= readMux;  // Held while busAck is high
        end
    end

    assign cfg.pnTaps     = pnTaps;
    assign cfg.pnLength   = pnLength;
    assign cfg.txEnable   = txEnable;
    assign cfg.gain0      = gain0;
    assign cfg.gain1      = gain1;
    assign cfg.dac0Source = dac0Source;
    assign cfg.dac1Source = dac1Source;

endmodule

`default_nettype wire

/* verif/stcModTb.sv */
// Testbench for the STC modulator covering register access, framing, PN payload and enable
`timescale 1ns/1ps
`default_nettype none

module stcModTb import stcPkg::*; ();

    localparam int          ClkPeriod     = 8;
    localparam int          SymbolDiv     = 4;
    localparam logic [15:0] VersionNumber = 16'd539;
    localparam int          TotalSymbols  = 11 * FrameLen;  // 10 frames tested plus one spare
    localparam int          TimeoutNs     = TotalSymbols * SymbolDiv * ClkPeriod + 20000;

    logic    clk;
    logic    reset;
    logic    busReq;
    logic    busWrite;
    busAddrT busAddr;
    busDataT busWrData;
    logic    busAck;
    busDataT busRdData;
    dacWordT dac0Data;
    dacWordT dac1Data;
    logic    dacValid;
    logic    dacFrameStart;

    logic [31:0] lfsrState = 32'h30f3;
    pnTapsT      cfgTaps;     // Shadow of the DUT configuration
    pnLenT       cfgLen;
    logic [15:0] cfgGain0;
    logic [15:0] cfgGain1;
    logic [3:0]  cfgSrc0;
    logic [3:0]  cfgSrc1;
    busDataT     regExpect [0:5];  // Last readback value per register
    int          modelIdx = 0;
    logic        modelPrev = 1'b0;
    pnTapsT      modelPn;
    int          checkedCount = 0;
    int          cycleCount = 0;
    int          lastValidCycle = 0;
    int          writeAcceptCycle = 0;

    stcModTop #(
        .VersionNumber(VersionNumber),
        .SymbolDiv    (SymbolDiv)
    ) dut (
        .clk           (clk),
        .reset         (reset),
        .busReq        (busReq),
        .busWrite      (busWrite),
        .busAddr       (busAddr),
        .busWrData     (busWrData),
        .busAck        (busAck),
        .busRdData     (busRdData),
        .dac0Data      (dac0Data),
        .dac1Data      (dac1Data),
        .dacValid      (dacValid),
        .dacFrameStart (dacFrameStart)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    always @(posedge clk) cycleCount <= cycleCount + 1;

    task automatic stopOnError(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else
            stopOnError($sformatf("ERR %s got %h expected %h", name, got, exp));
    endtask

    //**************************************************************************
    // Stimulus helpers
    //**************************************************************************
    function automatic logic [31:0] randomBits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            // Galois step for x^32 + x^22 + x^2 + x + 1
            lfsrState = lfsrState[0] ? (lfsrState >> 1) ^ 32'h80200003 : lfsrState >> 1;
            value = {value[30:0], lfsrState[0]};
        end
        return value;
    endfunction

    task automatic waitAck(input logic level);
        int cycles;
        cycles = 0;
        while (busAck !== level) begin
            @(negedge clk);
            cycles++;
            if (cycles > 10) begin
                stopOnError($sformatf("Bus handshake stuck, busAck never went to %0d", level));
            end
        end
    endtask

    task automatic busWriteReg(input busAddrT addr, input busDataT data);
        @(negedge clk);
        busReq    = 1'b1;
        busWrite  = 1'b1;
        busAddr   = addr;
        busWrData = data;
        waitAck(1'b1);
        writeAcceptCycle = cycleCount;  // Register took the value on this edge
        busReq = 1'b0;
        waitAck(1'b0);
    endtask

    task automatic busReadReg(input busAddrT addr, output busDataT data);
        @(negedge clk);
        busReq   = 1'b1;
        busWrite = 1'b0;
        busAddr  = addr;
        waitAck(1'b1);
        data   = busRdData;
        busReq = 1'b0;
        waitAck(1'b0);
    endtask

    task automatic readCheck(input busAddrT addr, input busDataT exp);
        busDataT rd;
        busReadReg(addr, rd);
        checkValue($sformatf("busRdData addr %h", addr), rd, exp);
    endtask

    task automatic readbackTest(input busAddrT addr, input busDataT fieldMask);
        busDataT value;
        value = randomBits(32);
        if (addr == RegControl) value[CtlTxEnable] = 1'b0;  // Keep transmitter idle
        regExpect[addr] = value & fieldMask;
        busWriteReg(addr, value);
        readCheck(addr, value & fieldMask);
    endtask

    //**************************************************************************
    // Reference model
    //**************************************************************************
    function automatic pnTapsT activeMask(input pnLenT len);
        logic [63:0] wide;
        wide = (64'd1 << (len + 1)) - 64'd1;
        return wide[PnW-1:0];
    endfunction

    function automatic pnTapsT pnNext(input pnTapsT state);
        pnTapsT next;
        next = state >> 1;
        if (state[0]) next = next ^ (cfgTaps & activeMask(cfgLen));
        return next & activeMask(cfgLen);
    endfunction

    function automatic int chanSample(input logic b, input logic [15:0] gain);
        int g;
        g = $signed(gain);
        return b ? g : -g;
    endfunction

    function automatic int sourceSample(input logic [3:0] src, input logic ownBit,
                                        input logic b0, input logic b1, input logic first);
        int bitLevel;
        bitLevel = 1 << (SampleW - 2);
        case (src)
            SrcCh1:   return chanSample(b1, cfgGain1);
            SrcTx:    return chanSample(b0, cfgGain0) + chanSample(b1, cfgGain1);
            SrcBits:  return ownBit ? bitLevel : 0;
            SrcFrame: return first ? -(1 << (SampleW - 1)) : (b0 ? bitLevel : 0);
            default:  return chanSample(b0, cfgGain0);
        endcase
    endfunction

    // Offset binary by biasing to unsigned and dropping the low bits
    function automatic dacWordT offsetWord(input int s);
        int biased;
        biased = (s + (1 << (SampleW - 1))) >> (SampleW - DacW);
        return biased[DacW-1:0];
    endfunction

    function automatic logic [2*DacW-1:0] refWords(input logic b0, input logic b1,
                                                   input logic first);
        return {offsetWord(sourceSample(cfgSrc0, b0, b0, b1, first)),
                offsetWord(sourceSample(cfgSrc1, b1, b0, b1, first))};
    endfunction

    // One model step per DAC update
    task automatic checkSymbol();
        logic              b0;
        logic              b1;
        logic              first;
        logic [2*DacW-1:0] exp;
        first = (modelIdx == 0);
        if (modelIdx < SyncLen) begin
            b0 = SyncWord0[SyncLen-1-modelIdx];
            b1 = SyncWord1[SyncLen-1-modelIdx];
        end else begin
            b0 = modelPn[0];
            b1 = (modelIdx == SyncLen) ? 1'b1 : ~modelPrev;
            modelPrev = b0;
            modelPn = pnNext(modelPn);
        end
        exp = refWords(b0, b1, first);
        checkValue($sformatf("dac0Data sym %0d", modelIdx), dac0Data, exp[2*DacW-1:DacW]);
        checkValue($sformatf("dac1Data sym %0d", modelIdx), dac1Data, exp[DacW-1:0]);
        checkValue($sformatf("dacFrameStart sym %0d", modelIdx), dacFrameStart, first);
        modelIdx = (modelIdx + 1) % FrameLen;
        checkedCount++;
        lastValidCycle = cycleCount;
    endtask

    always @(negedge clk) begin
        if (!reset && dacValid) checkSymbol();
    end

    // Bound assertion failures end the run at once
    always @(negedge clk) begin
        if (dut.props.failCount != 0) stopOnError("A bound assertion on the DUT failed");
    end

    //**************************************************************************
    // Test sequence
    //**************************************************************************
    task automatic configure(input pnTapsT taps, input pnLenT len);
        cfgTaps  = taps;
        cfgLen   = len;
        cfgGain0 = 16'(randomBits(16));
        cfgGain1 = 16'(randomBits(16));
        busWriteReg(RegPnTaps, busDataT'(cfgTaps));
        busWriteReg(RegPnLength, busDataT'(cfgLen));
        busWriteReg(RegGain0, busDataT'(cfgGain0));
        busWriteReg(RegGain1, busDataT'(cfgGain1));
    endtask

    task automatic runTx(input logic [3:0] src0, input logic [3:0] src1, input int frames);
        cfgSrc0      = src0;
        cfgSrc1      = src1;
        modelIdx     = 0;
        modelPrev    = 1'b0;
        modelPn      = activeMask(cfgLen);  // Held at all ones while idle
        checkedCount = 0;
        busWriteReg(RegControl, {20'h0, src1, src0, 4'b0001});
        wait (checkedCount >= frames * FrameLen);
    endtask

    task automatic stopTx();
        busWriteReg(RegControl, {20'h0, cfgSrc1, cfgSrc0, 4'b0000});
        repeat (4 * SymbolDiv) @(negedge clk);
        assert (lastValidCycle <= writeAcceptCycle + SymbolDiv + 2) else
            stopOnError("dacValid kept pulsing after txEnable was cleared");
    endtask

    initial begin
        reset     = 1'b1;
        busReq    = 1'b0;
        busWrite  = 1'b0;
        busAddr   = '0;
        busWrData = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Idle outputs
        checkValue("dac0Data after reset", dac0Data, offsetWord(0));
        checkValue("dac1Data after reset", dac1Data, offsetWord(0));
        checkValue("dacValid after reset", dacValid, 1'b0);

        // Register access
        readCheck(RegVersion, 32'(VersionNumber));
        readCheck(RegPnLength, 32'd23);
        readCheck(RegControl, 32'd0);
        readbackTest(RegPnTaps, 32'h00FF_FFFF);
        readbackTest(RegPnLength, 32'h0000_001F);
        readbackTest(RegControl, 32'h0000_0FF1);
        readbackTest(RegGain0, 32'h0000_FFFF);
        readbackTest(RegGain1, 32'h0000_FFFF);
        busWriteReg(4'hA, randomBits(32));
        readCheck(4'hA, 32'd0);
        busWriteReg(RegVersion, randomBits(32));
        readCheck(RegVersion, 32'(VersionNumber));
        // Stray writes leave the writable fields unchanged
        for (int a = RegPnTaps; a <= RegGain1; a++) begin
            readCheck(busAddrT'(a), regExpect[a]);
        end

        // Frame structure on raw bits
        configure(pnTapsT'(randomBits(PnW)), 5'd23);
        runTx(SrcBits, SrcBits, 2);
        stopTx();

        // PN payload on gained channels
        configure(pnTapsT'(randomBits(PnW)), 5'd15);
        runTx(SrcCh0, SrcCh1, 3);
        stopTx();

        // Channel sum and frame marker
        configure(pnTapsT'(randomBits(PnW)), 5'd15);
        runTx(SrcTx, SrcFrame, 2);
        stopTx();

        // Enable control with restart from symbol 0
        runTx(SrcCh0, SrcCh1, 1);
        stopTx();
        runTx(SrcCh0, SrcCh1, 2);
        stopTx();

        if (dut.props.failCount == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            stopOnError("A bound assertion on the DUT failed");
        end
    end

    initial begin : watchdog
        #(TimeoutNs);
        stopOnError("Timeout, the test sequence did not complete in time");
    end

endmodule

`default_nettype wire

/* verif/stcMod_props.sv */
// Bound checks on the register bus handshake and the DAC output strobes
`timescale 1ns/1ps
`default_nettype none

module stcModProps #(
    parameter int SymbolDiv = 4
) (
    input logic clk,
    input logic reset,
    input logic busReq,
    input logic busAck,
    input logic dacValid,
    input logic dacFrameStart
);

    int failCount = 0;  // Failed assertions so far

    // Ack only answers a pending request
    ackRiseWithReq: assert property (@(posedge clk) disable iff (reset)
        $rose(busAck) |-> $past(busReq))
        else begin
            $error("busAck rose while busReq was low");
            failCount++;
        end

    ackFallAfterReq: assert property (@(posedge clk) disable iff (reset)
        $fell(busAck) |-> !$past(busReq))
        else begin
            $error("busAck fell while busReq was still high");
            failCount++;
        end

    frameStartWithValid: assert property (@(posedge clk) disable iff (reset)
        dacFrameStart |-> dacValid)
        else begin
            $error("dacFrameStart high without dacValid");
            failCount++;
        end

    // One update per symbol at most
    validSpacing: assert property (@(posedge clk) disable iff (reset)
        dacValid |=> !dacValid [*SymbolDiv-1])
        else begin
            $error("dacValid pulses closer than SymbolDiv cycles");
            failCount++;
        end

endmodule

bind stcModTop stcModProps #(.SymbolDiv(SymbolDiv)) props (
    .clk           (clk),
    .reset         (reset),
    .busReq        (busReq),
    .busAck        (busAck),
    .dacValid      (dacValid),
    .dacFrameStart (dacFrameStart)
);

`default_nettype wire
